/* logic/exe_pkg.sv */
package exe_pkg;

    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;
    localparam int op_width       = 4;

    // alu operations
    localparam logic [op_width-1:0] alu_add  = 4'd0;
    localparam logic [op_width-1:0] alu_sub  = 4'd1;
    localparam logic [op_width-1:0] alu_slt  = 4'd2;
    localparam logic [op_width-1:0] alu_sltu = 4'd3;
    localparam logic [op_width-1:0] alu_and  = 4'd4;
    localparam logic [op_width-1:0] alu_or   = 4'd5;
    localparam logic [op_width-1:0] alu_xor  = 4'd6;
    localparam logic [op_width-1:0] alu_nor  = 4'd7;
    localparam logic [op_width-1:0] alu_sll  = 4'd8;
    localparam logic [op_width-1:0] alu_srl  = 4'd9;
    localparam logic [op_width-1:0] alu_sra  = 4'd10;
    localparam logic [op_width-1:0] alu_lui  = 4'd11;

    // branch conditions
    localparam logic [op_width-1:0] br_jirl = 4'd3;
    localparam logic [op_width-1:0] br_b    = 4'd4;
    localparam logic [op_width-1:0] br_bl   = 4'd5;
    localparam logic [op_width-1:0] br_beq  = 4'd6;
    localparam logic [op_width-1:0] br_bne  = 4'd7;
    localparam logic [op_width-1:0] br_blt  = 4'd8;
    localparam logic [op_width-1:0] br_bge  = 4'd9;
    localparam logic [op_width-1:0] br_bltu = 4'd10;
    localparam logic [op_width-1:0] br_bgeu = 4'd11;

    // predictor categories
    localparam logic [1:0] cat_cond     = 2'd0;
    localparam logic [1:0] cat_jump     = 2'd1;
    localparam logic [1:0] cat_call     = 2'd2;
    localparam logic [1:0] cat_indirect = 2'd3;

    localparam logic [xlen-1:0] link_offset = 32'd4;

    // one opcode field decoded per unit
    typedef union packed {
        logic [op_width-1:0] alu_op;
        logic [op_width-1:0] br_cond;
        struct packed {
            logic       high;
            logic       is_signed;
            logic [1:0] spare;
        } mul;
    } exe_op_u;

endpackage

/* logic/exe_alu.sv */
module exe_alu (
    input  exe_pkg::exe_op_u         op,
    input  logic [exe_pkg::xlen-1:0] src0,
    input  logic [exe_pkg::xlen-1:0] src1,
    output logic [exe_pkg::xlen-1:0] result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = src1[4:0];
    assign lt_signed   = $signed(src0) < $signed(src1);
    assign lt_unsigned = src0 < src1;

    always_comb begin
        case (op.alu_op)
            exe_pkg::alu_add: begin
                result = src0 + src1;
            end
            exe_pkg::alu_sub: begin
                result = src0 - src1;
            end
            exe_pkg::alu_slt: begin
                result = {{(exe_pkg::xlen-1){1'b0}}, lt_signed};
            end
            exe_pkg::alu_sltu: begin
                result = {{(exe_pkg::xlen-1){1'b0}}, lt_unsigned};
            end
            exe_pkg::alu_and: begin
                result = src0 & src1;
            end
            exe_pkg::alu_or: begin
                result = src0 | src1;
            end
            exe_pkg::alu_xor: begin
                result = src0 ^ src1;
            end
            exe_pkg::alu_nor: begin
                result = ~(src0 | src1);
            end
            exe_pkg::alu_sll: begin
                result = src0 << shamt;
            end
            exe_pkg::alu_srl: begin
                result = src0 >> shamt;
            end
            exe_pkg::alu_sra: begin
                result = $signed(src0) >>> shamt;
            end
            // upper immediate arrives already shifted
            exe_pkg::alu_lui: begin
                result = src1;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* logic/exe_branch.sv */
module exe_branch (
    input  logic                     en,
    input  exe_pkg::exe_op_u         op,
    input  logic [exe_pkg::xlen-1:0] pc,
    input  logic [exe_pkg::xlen-1:0] pc_next,
    input  logic [exe_pkg::xlen-1:0] imm,
    input  logic [exe_pkg::xlen-1:0] src0,
    input  logic [exe_pkg::xlen-1:0] src1,
    output logic [exe_pkg::xlen-1:0] link_data,
    output logic                     link_en,
    output logic                     mispredict,
    output logic [exe_pkg::xlen-1:0] correct_pc,
    output logic [exe_pkg::xlen-1:0] target,
    output logic                     taken,
    output logic                     valid,
    output logic [1:0]               category
);

    logic [exe_pkg::xlen-1:0] seq_pc;
    logic                     is_jirl;
    logic                     is_bl;

    assign is_jirl = op.br_cond == exe_pkg::br_jirl;
    assign is_bl   = op.br_cond == exe_pkg::br_bl;
    assign seq_pc  = pc + exe_pkg::link_offset;

    // jirl is register relative, the rest pc relative
    assign target = is_jirl ? src0 + imm : pc + imm;

    always_comb begin
        case (op.br_cond)
            exe_pkg::br_jirl, exe_pkg::br_b, exe_pkg::br_bl: taken = 1'b1;
            exe_pkg::br_beq:  taken = src0 == src1;
            exe_pkg::br_bne:  taken = src0 != src1;
            exe_pkg::br_blt:  taken = $signed(src0) < $signed(src1);
            exe_pkg::br_bge:  taken = $signed(src0) >= $signed(src1);
            exe_pkg::br_bltu: taken = src0 < src1;
            exe_pkg::br_bgeu: taken = src0 >= src1;
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        case (op.br_cond)
            exe_pkg::br_jirl: category = exe_pkg::cat_indirect;
            exe_pkg::br_b:    category = exe_pkg::cat_jump;
            exe_pkg::br_bl:   category = exe_pkg::cat_call;
            default:          category = exe_pkg::cat_cond;
        endcase
    end

    assign correct_pc = taken ? target : seq_pc;
    assign valid      = en;
    assign mispredict = en && correct_pc != pc_next;

    // return address for bl and jirl
    assign link_en   = en && (is_bl || is_jirl);
    assign link_data = seq_pc;

endmodule

/* logic/exe_mul_partial.sv */
module exe_mul_partial (
    input  logic [exe_pkg::xlen-1:0] src0,
    input  logic [exe_pkg::xlen-1:0] src1,
    input  exe_pkg::exe_op_u         op,
    output logic [exe_pkg::xlen-1:0] pp_hh,
    output logic [exe_pkg::xlen-1:0] pp_hl,
    output logic [exe_pkg::xlen-1:0] pp_lh,
    output logic [exe_pkg::xlen-1:0] pp_ll,
    output logic [exe_pkg::xlen-1:0] adjust
);

    localparam int half = exe_pkg::xlen / 2;

    logic [half-1:0]          src0_hi;
    logic [half-1:0]          src0_lo;
    logic [half-1:0]          src1_hi;
    logic [half-1:0]          src1_lo;
    logic [exe_pkg::xlen-1:0] neg_terms;

    assign src0_hi = src0[exe_pkg::xlen-1:half];
    assign src0_lo = src0[half-1:0];
    assign src1_hi = src1[exe_pkg::xlen-1:half];
    assign src1_lo = src1[half-1:0];

    // unsigned 16x16 products
    assign pp_hh = src0_hi * src1_hi;
    assign pp_hl = src0_hi * src1_lo;
    assign pp_lh = src0_lo * src1_hi;
    assign pp_ll = src0_lo * src1_lo;

    // a negative operand weighs -2^32 times the other one,
    // which only touches the upper word
    assign neg_terms = (src0[exe_pkg::xlen-1] ? src1 : '0)
                     + (src1[exe_pkg::xlen-1] ? src0 : '0);

    assign adjust = op.mul.is_signed ? -neg_terms : '0;

endmodule

/* logic/exe_mul_sum.sv */
module exe_mul_sum (
    input  logic [exe_pkg::xlen-1:0] pp_hh,
    input  logic [exe_pkg::xlen-1:0] pp_hl,
    input  logic [exe_pkg::xlen-1:0] pp_lh,
    input  logic [exe_pkg::xlen-1:0] pp_ll,
    input  logic [exe_pkg::xlen-1:0] adjust,
    input  logic                     high,
    output logic [exe_pkg::xlen-1:0] result
);

    localparam int half = exe_pkg::xlen / 2;

    logic [2*exe_pkg::xlen-1:0] product;
    logic [exe_pkg::xlen-1:0]   upper;

    // hh and ll do not overlap, so they concatenate
    assign product = {pp_hh, pp_ll}
                   + ({{exe_pkg::xlen{1'b0}}, pp_hl} << half)
                   + ({{exe_pkg::xlen{1'b0}}, pp_lh} << half);

    assign upper  = product[2*exe_pkg::xlen-1:exe_pkg::xlen] + adjust;
    assign result = high ? upper : product[exe_pkg::xlen-1:0];

endmodule

/* logic/exe_forward.sv */
module exe_forward (
    input  logic [exe_pkg::reg_addr_width-1:0] rj0,
    input  logic [exe_pkg::reg_addr_width-1:0] rk0,
    input  logic [exe_pkg::reg_addr_width-1:0] rj1,
    input  logic [exe_pkg::reg_addr_width-1:0] rk1,
    input  logic [exe_pkg::xlen-1:0]           rf00,
    input  logic [exe_pkg::xlen-1:0]           rf01,
    input  logic [exe_pkg::xlen-1:0]           rf10,
    input  logic [exe_pkg::xlen-1:0]           rf11,
    input  logic                               mid0_en,
    input  logic [exe_pkg::reg_addr_width-1:0] mid0_rd,
    input  logic [exe_pkg::xlen-1:0]           mid0_data,
    input  logic                               mid1_en,
    input  logic [exe_pkg::reg_addr_width-1:0] mid1_rd,
    input  logic [exe_pkg::xlen-1:0]           mid1_data,
    input  logic                               out0_en,
    input  logic [exe_pkg::reg_addr_width-1:0] out0_rd,
    input  logic [exe_pkg::xlen-1:0]           out0_data,
    input  logic                               out1_en,
    input  logic [exe_pkg::reg_addr_width-1:0] out1_rd,
    input  logic [exe_pkg::xlen-1:0]           out1_data,
    output logic [exe_pkg::xlen-1:0]           src00,
    output logic [exe_pkg::xlen-1:0]           src01,
    output logic [exe_pkg::xlen-1:0]           src10,
    output logic [exe_pkg::xlen-1:0]           src11
);

    // youngest result wins and lane 1 goes before lane 0
    function automatic logic [exe_pkg::xlen-1:0] pick(
        input logic [exe_pkg::reg_addr_width-1:0] idx,
        input logic [exe_pkg::xlen-1:0]           rf
    );
        return (mid1_en && mid1_rd == idx) ? mid1_data :
               (mid0_en && mid0_rd == idx) ? mid0_data :
               (out1_en && out1_rd == idx) ? out1_data :
               (out0_en && out0_rd == idx) ? out0_data :
               rf;
    endfunction

    always_comb begin
        src00 = pick(rj0, rf00);
        src01 = pick(rk0, rf01);
        src10 = pick(rj1, rf10);
        src11 = pick(rk1, rf11);
    end

endmodule

/* logic/exe_stage.sv */
module exe_stage (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               flush_by_writeback,
    input  logic                               eu0_en,
    input  logic                               eu0_is_alu,
    input  logic                               eu0_is_mul,
    input  logic                               eu0_is_br,
    input  logic                               eu0_src2_imm,
    input  exe_pkg::exe_op_u                   eu0_op,
    input  logic [exe_pkg::reg_addr_width-1:0] eu0_rd,
    input  logic [exe_pkg::reg_addr_width-1:0] eu0_rj,
    input  logic [exe_pkg::reg_addr_width-1:0] eu0_rk,
    input  logic [exe_pkg::xlen-1:0]           eu0_imm,
    input  logic [exe_pkg::xlen-1:0]           eu0_pc,
    input  logic [exe_pkg::xlen-1:0]           eu0_pc_next,
    input  logic                               eu1_en,
    input  logic                               eu1_src2_imm,
    input  exe_pkg::exe_op_u                   eu1_op,
    input  logic [exe_pkg::reg_addr_width-1:0] eu1_rd,
    input  logic [exe_pkg::reg_addr_width-1:0] eu1_rj,
    input  logic [exe_pkg::reg_addr_width-1:0] eu1_rk,
    input  logic [exe_pkg::xlen-1:0]           eu1_imm,
    input  logic [exe_pkg::xlen-1:0]           data00,
    input  logic [exe_pkg::xlen-1:0]           data01,
    input  logic [exe_pkg::xlen-1:0]           data10,
    input  logic [exe_pkg::xlen-1:0]           data11,
    output logic                               en_out0,
    output logic [exe_pkg::xlen-1:0]           data_out0,
    output logic [exe_pkg::reg_addr_width-1:0] addr_out0,
    output logic                               en_out1,
    output logic [exe_pkg::xlen-1:0]           data_out1,
    output logic [exe_pkg::reg_addr_width-1:0] addr_out1,
    output logic                               flush,
    output logic [exe_pkg::xlen-1:0]           correct_pc_next,
    output logic [exe_pkg::xlen-1:0]           branch_pc,
    output logic                               branch_valid,
    output logic                               branch_status,
    output logic [1:0]                         category_out,
    output logic [exe_pkg::xlen-1:0]           ex_pc_tar
);

    logic [exe_pkg::xlen-1:0] src00;
    logic [exe_pkg::xlen-1:0] src01;
    logic [exe_pkg::xlen-1:0] src10;
    logic [exe_pkg::xlen-1:0] src11;
    logic [exe_pkg::xlen-1:0] alu0_result;
    logic [exe_pkg::xlen-1:0] alu1_result;
    logic [exe_pkg::xlen-1:0] br_link_data;
    logic                     br_link_en;
    logic                     br_mispredict;
    logic [exe_pkg::xlen-1:0] br_correct_pc;
    logic [exe_pkg::xlen-1:0] br_target;
    logic                     br_taken;
    logic                     br_valid;
    logic [1:0]               br_category;
    logic [exe_pkg::xlen-1:0] pp_hh;
    logic [exe_pkg::xlen-1:0] pp_hl;
    logic [exe_pkg::xlen-1:0] pp_lh;
    logic [exe_pkg::xlen-1:0] pp_ll;
    logic [exe_pkg::xlen-1:0] adjust;
    logic [exe_pkg::xlen-1:0] mul_result;

    // mid registers
    logic                               eu0_en_mid;
    logic [exe_pkg::reg_addr_width-1:0] eu0_rd_mid;
    logic [exe_pkg::xlen-1:0]           eu0_data_mid;
    logic                               eu1_en_mid;
    logic [exe_pkg::reg_addr_width-1:0] eu1_rd_mid;
    logic [exe_pkg::xlen-1:0]           eu1_data_mid;
    logic                               mul_en_mid;
    logic                               mul_high_mid;
    logic [exe_pkg::xlen-1:0]           pp_hh_mid;
    logic [exe_pkg::xlen-1:0]           pp_hl_mid;
    logic [exe_pkg::xlen-1:0]           pp_lh_mid;
    logic [exe_pkg::xlen-1:0]           pp_ll_mid;
    logic [exe_pkg::xlen-1:0]           adjust_mid;

    exe_forward u_forward (
        .rj0       (eu0_rj),
        .rk0       (eu0_rk),
        .rj1       (eu1_rj),
        .rk1       (eu1_rk),
        .rf00      (data00),
        .rf01      (data01),
        .rf10      (data10),
        .rf11      (data11),
        .mid0_en   (eu0_en_mid),
        .mid0_rd   (eu0_rd_mid),
        .mid0_data (eu0_data_mid),
        .mid1_en   (eu1_en_mid),
        .mid1_rd   (eu1_rd_mid),
        .mid1_data (eu1_data_mid),
        .out0_en   (en_out0),
        .out0_rd   (addr_out0),
        .out0_data (data_out0),
        .out1_en   (en_out1),
        .out1_rd   (addr_out1),
        .out1_data (data_out1),
        .src00     (src00),
        .src01     (src01),
        .src10     (src10),
        .src11     (src11)
    );

    exe_alu u_alu0 (
        .op     (eu0_op),
        .src0   (src00),
        .src1   (eu0_src2_imm ? eu0_imm : src01),
        .result (alu0_result)
    );

    exe_alu u_alu1 (
        .op     (eu1_op),
        .src0   (src10),
        .src1   (eu1_src2_imm ? eu1_imm : src11),
        .result (alu1_result)
    );

    exe_branch u_branch (
        .en         (eu0_en && eu0_is_br),
        .op         (eu0_op),
        .pc         (eu0_pc),
        .pc_next    (eu0_pc_next),
        .imm        (eu0_imm),
        .src0       (src00),
        .src1       (src01),
        .link_data  (br_link_data),
        .link_en    (br_link_en),
        .mispredict (br_mispredict),
        .correct_pc (br_correct_pc),
        .target     (br_target),
        .taken      (br_taken),
        .valid      (br_valid),
        .category   (br_category)
    );

    exe_mul_partial u_mul_partial (
        .src0   (src00),
        .src1   (src01),
        .op     (eu0_op),
        .pp_hh  (pp_hh),
        .pp_hl  (pp_hl),
        .pp_lh  (pp_lh),
        .pp_ll  (pp_ll),
        .adjust (adjust)
    );

    exe_mul_sum u_mul_sum (
        .pp_hh  (pp_hh_mid),
        .pp_hl  (pp_hl_mid),
        .pp_lh  (pp_lh_mid),
        .pp_ll  (pp_ll_mid),
        .adjust (adjust_mid),
        .high   (mul_high_mid),
        .result (mul_result)
    );

    // a mispredict kills whatever is issued behind it
    always_ff @(posedge clk) begin
        if (reset || flush_by_writeback || flush) begin
            eu0_en_mid   <= 1'b0;
            eu1_en_mid   <= 1'b0;
            mul_en_mid   <= 1'b0;
            branch_valid <= 1'b0;
            flush        <= 1'b0;
        end else begin
            // writes to r0 dropped here
            eu0_en_mid   <= ((eu0_en && eu0_is_alu) || br_link_en) && eu0_rd != '0;
            eu1_en_mid   <= eu1_en && eu1_rd != '0;
            mul_en_mid   <= eu0_en && eu0_is_mul && eu0_rd != '0;
            branch_valid <= br_valid;
            flush        <= br_mispredict;
        end
    end

    always_ff @(posedge clk) begin
        eu0_rd_mid      <= eu0_rd;
        eu0_data_mid    <= br_link_en ? br_link_data : alu0_result;
        eu1_rd_mid      <= eu1_rd;
        eu1_data_mid    <= alu1_result;
        mul_high_mid    <= eu0_op.mul.high;
        pp_hh_mid       <= pp_hh;
        pp_hl_mid       <= pp_hl;
        pp_lh_mid       <= pp_lh;
        pp_ll_mid       <= pp_ll;
        adjust_mid      <= adjust;
        branch_pc       <= eu0_pc;
        branch_status   <= br_taken;
        category_out    <= br_category;
        ex_pc_tar       <= br_target;
        correct_pc_next <= br_correct_pc;
    end

    // a branch flush leaves the out registers alone
    always_ff @(posedge clk) begin
        if (reset || flush_by_writeback) begin
            en_out0 <= 1'b0;
            en_out1 <= 1'b0;
        end else begin
            en_out0 <= eu0_en_mid || mul_en_mid;
            en_out1 <= eu1_en_mid;
        end
    end

    always_ff @(posedge clk) begin
        data_out0 <= mul_en_mid ? mul_result : eu0_data_mid;
        addr_out0 <= eu0_rd_mid;
        data_out1 <= eu1_data_mid;
        addr_out1 <= eu1_rd_mid;
    end

endmodule

/* dv/exe_stage_asserts.sv */
module exe_stage_asserts (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic branch_valid,
    input logic en_out0,
    input logic en_out1
);

    // failed assertion count
    int unsigned fail_count = 0;

    // a flush only comes from a resolved branch
    flush_needs_branch: assert property (
        @(posedge clk) disable iff (reset) flush |-> branch_valid
    ) else begin
        $error("flush raised without a valid branch");
        fail_count++;
    end

    no_writeback_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> !en_out0 && !en_out1
    ) else begin
        $error("writeback enabled in the cycle after reset");
        fail_count++;
    end

    // the bundle behind a mispredict never reaches lane 0 writeback
    flush_kills_lane0: assert property (
        @(posedge clk) disable iff (reset) flush |-> ##2 !en_out0
    ) else begin
        $error("lane 0 wrote back a flushed bundle");
        fail_count++;
    end

endmodule

/* dv/exe_stage_tb.sv */
module exe_stage_tb;

    localparam int n_lines  = 34;
    localparam int n_fields = 21;
    localparam int wd_limit = (n_lines + 20) * 8 * 2;

    // column positions within one testdata line
    localparam int f_en0  = 0;
    localparam int f_kind = 1;
    localparam int f_sel0 = 2;
    localparam int f_op0  = 3;
    localparam int f_rd0  = 4;
    localparam int f_rj0  = 5;
    localparam int f_rk0  = 6;
    localparam int f_imm0 = 7;
    localparam int f_pc   = 8;
    localparam int f_pcn  = 9;
    localparam int f_en1  = 10;
    localparam int f_sel1 = 11;
    localparam int f_op1  = 12;
    localparam int f_rd1  = 13;
    localparam int f_rj1  = 14;
    localparam int f_rk1  = 15;
    localparam int f_imm1 = 16;
    localparam int f_exp0 = 17;
    localparam int f_exp1 = 18;
    localparam int f_mp   = 19;
    localparam int f_cpc  = 20;

    typedef struct packed {
        logic        en0;
        logic [4:0]  rd0;
        logic [31:0] data0;
        logic        en1;
        logic [4:0]  rd1;
        logic [31:0] data1;
    } wb_exp_t;

    logic clk;
    logic reset;
    logic flush_by_writeback;
    logic eu0_en;
    logic eu0_is_alu;
    logic eu0_is_mul;
    logic eu0_is_br;
    logic eu0_src2_imm;
    exe_pkg::exe_op_u eu0_op;
    logic [4:0]  eu0_rd;
    logic [4:0]  eu0_rj;
    logic [4:0]  eu0_rk;
    logic [31:0] eu0_imm;
    logic [31:0] eu0_pc;
    logic [31:0] eu0_pc_next;
    logic eu1_en;
    logic eu1_src2_imm;
    exe_pkg::exe_op_u eu1_op;
    logic [4:0]  eu1_rd;
    logic [4:0]  eu1_rj;
    logic [4:0]  eu1_rk;
    logic [31:0] eu1_imm;
    logic [31:0] data00;
    logic [31:0] data01;
    logic [31:0] data10;
    logic [31:0] data11;
    logic        en_out0;
    logic [31:0] data_out0;
    logic [4:0]  addr_out0;
    logic        en_out1;
    logic [31:0] data_out1;
    logic [4:0]  addr_out1;
    logic        flush;
    logic [31:0] correct_pc_next;
    logic [31:0] branch_pc;
    logic        branch_valid;
    logic        branch_status;
    logic [1:0]  category_out;
    logic [31:0] ex_pc_tar;

    logic [31:0] rf [0:31];
    logic [31:0] testdata [0:n_lines*n_fields-1];
    logic        killed [0:n_lines-1];
    wb_exp_t     wb_queue [$];
    integer      seed;

    // register file model feeds the read ports
    assign data00 = rf[eu0_rj];
    assign data01 = rf[eu0_rk];
    assign data10 = rf[eu1_rj];
    assign data11 = rf[eu1_rk];

    exe_stage dut0 (.*);

    bind exe_stage exe_stage_asserts u_asserts (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .branch_valid (branch_valid),
        .en_out0      (en_out0),
        .en_out1      (en_out1)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] field(input int ln, input int idx);
        return testdata[ln * n_fields + idx];
    endfunction

    function automatic logic [1:0] exp_category(input logic [3:0] op);
        case (op)
            exe_pkg::br_jirl: return exe_pkg::cat_indirect;
            exe_pkg::br_b:    return exe_pkg::cat_jump;
            exe_pkg::br_bl:   return exe_pkg::cat_call;
            default:          return exe_pkg::cat_cond;
        endcase
    endfunction

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: time %0t signal %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic random_lanes(input logic lane0, input logic lane1);
        if (lane0) begin
            eu0_en       <= 1'b0;
            eu0_is_alu   <= $random(seed);
            eu0_is_mul   <= $random(seed);
            eu0_is_br    <= $random(seed);
            eu0_src2_imm <= $random(seed);
            eu0_op       <= $random(seed);
            eu0_rd       <= $random(seed);
            eu0_rj       <= $random(seed);
            eu0_rk       <= $random(seed);
            eu0_imm      <= $random(seed);
            eu0_pc       <= $random(seed);
            eu0_pc_next  <= $random(seed);
        end
        if (lane1) begin
            eu1_en       <= 1'b0;
            eu1_src2_imm <= $random(seed);
            eu1_op       <= $random(seed);
            eu1_rd       <= $random(seed);
            eu1_rj       <= $random(seed);
            eu1_rk       <= $random(seed);
            eu1_imm      <= $random(seed);
        end
    endtask

    task automatic drive_line(input int ln);
        logic [31:0] f [n_fields];
        wb_exp_t     rec;
        logic        link;
        for (int i = 0; i < n_fields; i++) begin
            f[i] = field(ln, i);
        end
        random_lanes(f[f_en0] == 0, f[f_en1] == 0);
        if (f[f_en0] != 0) begin
            eu0_en       <= 1'b1;
            eu0_is_alu   <= f[f_kind] == 0;
            eu0_is_mul   <= f[f_kind] == 1;
            eu0_is_br    <= f[f_kind] == 2;
            eu0_src2_imm <= f[f_sel0][0];
            eu0_op       <= f[f_op0][3:0];
            eu0_rd       <= f[f_rd0][4:0];
            eu0_rj       <= f[f_rj0][4:0];
            eu0_rk       <= f[f_rk0][4:0];
            eu0_imm      <= f[f_imm0];
            eu0_pc       <= f[f_pc];
            eu0_pc_next  <= f[f_pcn];
        end
        if (f[f_en1] != 0) begin
            eu1_en       <= 1'b1;
            eu1_src2_imm <= f[f_sel1][0];
            eu1_op       <= f[f_op1][3:0];
            eu1_rd       <= f[f_rd1][4:0];
            eu1_rj       <= f[f_rj1][4:0];
            eu1_rk       <= f[f_rk1][4:0];
            eu1_imm      <= f[f_imm1];
        end
        // only bl and jirl write a link register
        link = f[f_kind] != 2 || f[f_op0][3:0] == exe_pkg::br_bl
            || f[f_op0][3:0] == exe_pkg::br_jirl;
        rec.en0   = f[f_en0] != 0 && !killed[ln] && f[f_rd0][4:0] != 0 && link;
        rec.rd0   = f[f_rd0][4:0];
        rec.data0 = f[f_exp0];
        rec.en1   = f[f_en1] != 0 && !killed[ln] && f[f_rd1][4:0] != 0;
        rec.rd1   = f[f_rd1][4:0];
        rec.data1 = f[f_exp1];
        wb_queue.push_back(rec);
    endtask

    task automatic check_branch(input int ln);
        logic        br;
        logic        taken;
        logic [31:0] cpc;
        br    = field(ln, f_en0) != 0 && field(ln, f_kind) == 2 && !killed[ln];
        cpc   = field(ln, f_cpc);
        taken = cpc != field(ln, f_pc) + 32'd4;
        check_value("branch_valid", branch_valid, br);
        check_value("flush", flush, br && field(ln, f_mp) != 0);
        if (br) begin
            check_value("branch_pc", branch_pc, field(ln, f_pc));
            check_value("correct_pc_next", correct_pc_next, cpc);
            check_value("branch_status", branch_status, taken);
            check_value("category_out", category_out, exp_category(field(ln, f_op0)));
            if (taken) begin
                check_value("ex_pc_tar", ex_pc_tar, cpc);
            end else begin
                check_value("ex_pc_tar", ex_pc_tar, field(ln, f_pc) + field(ln, f_imm0));
            end
        end
    endtask

    task automatic check_writeback(input wb_exp_t rec);
        check_value("en_out0", en_out0, rec.en0);
        check_value("en_out1", en_out1, rec.en1);
        if (rec.en0) begin
            check_value("addr_out0", addr_out0, rec.rd0);
            check_value("data_out0", data_out0, rec.data0);
            rf[rec.rd0] = rec.data0;
        end
        // lane 1 is younger, so it wins a same-register write
        if (rec.en1) begin
            check_value("addr_out1", addr_out1, rec.rd1);
            check_value("data_out1", data_out1, rec.data1);
            rf[rec.rd1] = rec.data1;
        end
    endtask

    initial begin
        #(wd_limit);
        $display("Error: watchdog expired before all bundles were checked");
        stop_run();
    end

    initial begin
        seed = 32'hb098;
        reset = 1'b1;
        flush_by_writeback = 1'b0;
        eu0_en = 1'b0;
        eu1_en = 1'b0;
        {eu0_is_alu, eu0_is_mul, eu0_is_br, eu0_src2_imm, eu1_src2_imm} = '0;
        eu0_op = '0;
        eu1_op = '0;
        {eu0_rd, eu0_rj, eu0_rk, eu1_rd, eu1_rj, eu1_rk} = '0;
        {eu0_imm, eu0_pc, eu0_pc_next, eu1_imm} = '0;
        for (int i = 0; i < 32; i++) begin
            rf[i] = 32'h0101_0101 * i;
        end
        $readmemh("dv/exe_stage_testdata.txt", testdata);
        // a mispredict discards the bundle right behind it
        for (int i = 0; i < n_lines; i++) begin
            killed[i] = i > 0 && !killed[i-1] && field(i - 1, f_en0) != 0
                && field(i - 1, f_kind) == 2 && field(i - 1, f_mp) != 0;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (int c = 0; c < n_lines + 2; c++) begin
            @(posedge clk);
            if (c < n_lines) begin
                drive_line(c);
            end else begin
                random_lanes(1'b1, 1'b1);
            end
            @(negedge clk);
            assert (dut0.u_asserts.fail_count == 0) else begin
                $display("Error: time %0t a bound assertion on the DUT failed", $time);
                stop_run();
            end
            if (c >= 1 && c <= n_lines) begin
                check_branch(c - 1);
            end
            if (c >= 2) begin
                check_writeback(wb_queue.pop_front());
            end
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* dv/exe_stage_testdata.txt */
// en0 kind sel0 op0 rd0 rj0 rk0 imm0 pc pc_next | en1 sel1 op1 rd1 rj1 rk1 imm1
// exp0 exp1 mispredict correct_pc   (kind 0 alu, 1 mul, 2 branch)
1 0 0 0 0a 01 02 0 0 0 1 1 1 0b 03 00 3 03030303 03030300 0 0
1 0 0 6 0c 0a 0b 0 0 0 1 1 5 0d 0b 00 f0 00000003 030303f0 0 0
1 0 0 4 0e 0a 0d 0 0 0 1 0 7 0f 0c 01 0 03030300 fefefefc 0 0
1 0 1 0 10 00 00 5 0 0 1 1 0 10 00 00 9 00000005 00000009 0 0
1 0 0 1 11 10 0e 0 0 0 1 0 3 12 10 0f 0 fcfcfd09 00000001 0 0
1 0 1 8 13 10 00 4 0 0 1 1 0 00 01 00 1 00000090 00000000 0 0
1 0 1 9 14 11 00 4 0 0 1 1 a 15 11 00 8 0fcfcfd0 fffcfcfd 0 0
1 0 0 2 16 11 01 0 0 0 1 1 b 17 00 00 12345000 00000001 12345000 0 0
1 0 0 5 18 01 02 0 0 0 1 1 4 19 03 00 ff 03030303 00000003 0 0
0 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 0 00000000 00000000 0 0
1 0 1 0 1a 00 00 fffffffd 0 0 1 1 0 1b 00 00 7 fffffffd 00000007 0 0
1 0 1 0 1c 00 00 10000 0 0 1 1 0 1d 00 00 30000 00010000 00030000 0 0
1 1 0 0 1e 1a 1b 0 0 0 0 0 0 00 00 00 0 ffffffeb 00000000 0 0
1 1 0 c 1f 1a 1b 0 0 0 0 0 0 00 00 00 0 ffffffff 00000000 0 0
1 1 0 8 1e 1c 1d 0 0 0 1 1 0 09 16 00 1 00000003 00000002 0 0
1 1 0 8 1f 1a 1b 0 0 0 0 0 0 00 00 00 0 00000006 00000000 0 0
1 0 1 0 08 1e 00 100 0 0 0 0 0 00 00 00 0 00000103 00000000 0 0
0 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 0 00000000 00000000 0 0
1 2 0 6 00 01 01 40 1c000000 1c000040 0 0 0 00 00 00 0 0 0 0 1c000040
1 2 0 7 00 01 01 80 1c000040 1c000044 0 0 0 00 00 00 0 0 0 0 1c000044
1 2 0 8 00 1a 1b 10 1c000100 1c000110 0 0 0 00 00 00 0 0 0 0 1c000110
1 2 0 9 00 1a 1b 20 1c000200 1c000204 0 0 0 00 00 00 0 0 0 0 1c000204
1 2 0 a 00 1a 1b 30 1c000300 1c000304 0 0 0 00 00 00 0 0 0 0 1c000304
1 2 0 b 00 1a 1b 8 1c000400 1c000408 0 0 0 00 00 00 0 0 0 0 1c000408
1 2 0 4 00 00 00 1000 1c000500 1c001500 0 0 0 00 00 00 0 0 0 0 1c001500
1 2 0 5 14 00 00 800 1c000600 1c000e00 0 0 0 00 00 00 0 1c000604 0 0 1c000e00
1 2 0 3 15 09 00 1c000000 1c000700 1c000002 0 0 0 00 00 00 0 1c000704 0 0 1c000002
1 2 0 6 00 01 02 40 1c000800 1c000840 1 1 0 06 00 00 66 0 00000066 1 1c000804
1 0 1 0 07 00 00 77 0 0 1 1 0 04 00 00 44 0 0 0 0
1 0 1 0 0a 06 00 1 0 0 1 0 5 0b 07 00 0 00000067 07070707 0 0
1 2 0 4 00 00 00 20 1c000900 1c000904 1 1 0 0c 0a 00 1 0 00000068 1 1c000920
1 0 1 0 0d 00 00 5 0 0 0 0 0 00 00 00 0 0 0 0 0
0 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 0 00000000 00000000 0 0
0 0 0 0 00 00 00 0 0 0 0 0 0 00 00 00 0 00000000 00000000 0 0

/* exe_stage.f */
logic/exe_pkg.sv
logic/exe_alu.sv
logic/exe_branch.sv
logic/exe_mul_partial.sv
logic/exe_mul_sum.sv
logic/exe_forward.sv
logic/exe_stage.sv
dv/exe_stage_asserts.sv
dv/exe_stage_tb.sv

/* Bender.yml */
package:
  name: exe_stage

sources:
  - logic/exe_pkg.sv
  - logic/exe_alu.sv
  - logic/exe_branch.sv
  - logic/exe_mul_partial.sv
  - logic/exe_mul_sum.sv
  - logic/exe_forward.sv
  - logic/exe_stage.sv
  - target: test
    files:
      - dv/exe_stage_asserts.sv
      - dv/exe_stage_tb.sv
